//--- tb.f
+incdir+logic
logic/noc_pkg.sv
logic/flit_link_if.sv
logic/req_packetizer.sv
logic/xy_route_unit.sv
logic/tile_req_demux.sv
logic/noc_group_endpoint.sv
tests/tb_noc_group_endpoint.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_noc_group_endpoint \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tests/tb_noc_group_endpoint.sv
// Testbench for the group network endpoint
// Random local and network traffic, credit sinks, XY reference model and checker

`timescale 1ns/1ps
`include "noc_consts.svh"

module tb_noc_group_endpoint;

  localparam noc_pkg::group_xy_t OWN_GROUP = {2'd1, 2'd2};
  localparam int N_LOCAL        = 150;
  localparam int N_NET          = 100;
  localparam int N_BP           = 40;
  localparam int TIMEOUT_CYCLES = (N_LOCAL + N_NET + N_BP) * 40 + 500;
  localparam int NET_DEST       = `NUM_TILES; // Queue slot after the tiles
  localparam int NUM_Q          = (`NUM_TILES + 1) * 2;

  typedef struct packed {
    logic [2:0]                   dest;     // Tile index or NET_DEST
    noc_pkg::dir_e                dir;
    logic [`ROW_W+`BANK_W-1:0]    row_bank;
    noc_pkg::req_hdr_t            hdr;
    noc_pkg::req_payload_t        payload;
  } exp_t;

  logic                      clk_i;
  logic                      rst_n_i;
  noc_pkg::group_xy_t        group_id_i;
  logic                      mst_req_valid_i;
  logic                      mst_req_ready_o;
  logic [`TCDM_ADDR_W-1:0]   mst_req_addr_i;
  noc_pkg::group_xy_t        mst_req_dst_group_i;
  logic [`CORE_ID_W-1:0]     mst_req_core_id_i;
  logic [`DATA_W-1:0]        mst_req_data_i;
  logic [`BE_W-1:0]          mst_req_be_i;
  logic                      mst_req_wen_i;
  logic                      net_in_valid_i;
  noc_pkg::req_hdr_t         net_in_hdr_i;
  noc_pkg::req_payload_t     net_in_payload_i;
  logic                      net_in_credit_o;
  logic                      net_out_valid_o;
  noc_pkg::req_hdr_t         net_out_hdr_o;
  noc_pkg::req_payload_t     net_out_payload_o;
  noc_pkg::dir_e             net_out_dir_o;
  logic                      net_out_credit_i;
  logic [`NUM_TILES-1:0]     tile_credit_i;
  logic [`NUM_TILES-1:0]     tile_req_valid_o;
  logic [`ROW_W+`BANK_W-1:0] tile_req_row_bank_o;
  logic [`CORE_ID_W-1:0]     tile_req_core_id_o;
  noc_pkg::group_xy_t        tile_req_src_group_o;
  logic [`DATA_W-1:0]        tile_req_data_o;
  logic [`BE_W-1:0]          tile_req_be_o;
  logic                      tile_req_wen_o;

  integer seed;
  exp_t   exp_q [NUM_Q][$]; // Indexed by destination * 2 + source
  int     checks;
  int     mismatches;
  int     other_errs;
  int     local_left;
  int     net_left;
  int     net_sent;
  int     net_credit_pulses;
  int     net_in_cnt;       // Credits held toward the incoming FIFO
  int     net_owed;
  int     tile_owed [`NUM_TILES];
  logic   hold_net;
  logic   hold_tile;
  int     wait_cycles;

  noc_group_endpoint i_noc_group_endpoint (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      mismatches++;
      $display("error at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  // Direction by XY order or tile and stripped address for the own group
  function automatic exp_t ref_result(input noc_pkg::group_xy_t own, input noc_pkg::req_hdr_t hdr,
                                      input noc_pkg::req_payload_t pay);
    exp_t                e;
    noc_pkg::tcdm_addr_u a;
    a          = hdr.tcdm_addr;
    e.hdr      = hdr;
    e.payload  = pay;
    e.row_bank = a.flat[`TCDM_ADDR_W-1:`TILE_W]; // Tile bits stripped
    e.dir      = noc_pkg::NORTH;
    e.dest     = 3'(NET_DEST);
    if (hdr.dst_group.x > own.x) begin
      e.dir = noc_pkg::EAST;
    end else if (hdr.dst_group.x < own.x) begin
      e.dir = noc_pkg::WEST;
    end else if (hdr.dst_group.y > own.y) begin
      e.dir = noc_pkg::NORTH;
    end else if (hdr.dst_group.y < own.y) begin
      e.dir = noc_pkg::SOUTH;
    end else begin
      e.dest = 3'(a.flat[`TILE_W-1:0]);
    end
    return e;
  endfunction

  task automatic random_flit(input noc_pkg::group_xy_t src, output noc_pkg::req_hdr_t hdr,
                             output noc_pkg::req_payload_t pay);
    logic [31:0] rnd;
    rnd                = $random(seed);
    hdr.src_group      = src;
    hdr.dst_group      = rnd[3:0];
    if (rnd[4]) hdr.dst_group = OWN_GROUP; // Half the traffic stays in the group
    hdr.core_id        = rnd[7:5];
    hdr.tcdm_addr.flat = rnd[17:8];
    pay.be             = rnd[21:18];
    pay.wen            = rnd[22];
    pay.data           = $random(seed);
  endtask

  task automatic push_expected(input int src, input noc_pkg::req_hdr_t hdr,
                               input noc_pkg::req_payload_t pay);
    exp_t e;
    e = ref_result(OWN_GROUP, hdr, pay);
    exp_q[int'(e.dest) * 2 + src].push_back(e);
  endtask

  function automatic bit queues_empty();
    for (int i = 0; i < NUM_Q; i++) begin
      if (exp_q[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Network and tile sinks return credits after random delays unless held
  task automatic sink_credits();
    net_out_credit_i = 1'b0;
    if (net_out_valid_o) begin
      net_owed++;
      if (net_owed > `NET_CREDITS) begin
        other_errs++;
        $display("net_out sent more flits than its credits allow at %0t", $time);
      end
    end
    if (!hold_net && net_owed > 0 && ($random(seed) & 1) != 0) begin
      net_out_credit_i = 1'b1;
      net_owed--;
    end
    for (int k = 0; k < `NUM_TILES; k++) begin
      tile_credit_i[k] = 1'b0;
      if (tile_req_valid_o[k]) begin
        tile_owed[k]++;
        if (tile_owed[k] > `TILE_CREDITS) begin
          other_errs++;
          $display("tile %0d got more requests than its credits allow at %0t", k, $time);
        end
      end
      if (!hold_tile && tile_owed[k] > 0 && ($random(seed) & 1) != 0) begin
        tile_credit_i[k] = 1'b1;
        tile_owed[k]--;
      end
    end
  endtask

  task automatic drive_net_in();
    noc_pkg::req_hdr_t     hdr;
    noc_pkg::req_payload_t pay;
    noc_pkg::group_xy_t    src;
    logic [31:0]           rnd;
    net_in_valid_i = 1'b0;
    if (net_in_credit_o) begin
      net_in_cnt++;
      net_credit_pulses++;
    end
    if (net_left > 0 && net_in_cnt > 0 && ($random(seed) & 3) == 0) begin
      rnd = $random(seed);
      src = rnd[3:0];
      if (src == OWN_GROUP) src.x = ~src.x; // Remote sources only
      random_flit(src, hdr, pay);
      net_in_hdr_i     = hdr;
      net_in_payload_i = pay;
      net_in_valid_i   = 1'b1;
      net_in_cnt--;
      net_left--;
      net_sent++;
      push_expected(1, hdr, pay);
    end
  endtask

  task automatic drive_master();
    noc_pkg::req_hdr_t     hdr;
    noc_pkg::req_payload_t pay;
    mst_req_valid_i = 1'b0;
    if (local_left > 0 && mst_req_ready_o && ($random(seed) & 1) != 0) begin
      random_flit(OWN_GROUP, hdr, pay);
      mst_req_valid_i     = 1'b1;
      mst_req_addr_i      = hdr.tcdm_addr.flat;
      mst_req_dst_group_i = hdr.dst_group;
      mst_req_core_id_i   = hdr.core_id;
      mst_req_data_i      = pay.data;
      mst_req_be_i        = pay.be;
      mst_req_wen_i       = pay.wen;
      local_left--;
      push_expected(0, hdr, pay);
    end
  endtask

  always @(posedge clk_i) begin
    #1;
    if (rst_n_i) begin
      sink_credits();
      drive_net_in();
      drive_master();
    end
  end

  // Pop the matching queue on every valid output
  always @(negedge clk_i) begin : compare_proc
    exp_t e;
    int   src;
    if (rst_n_i) begin
      if (net_out_valid_o) begin
        src = (net_out_hdr_o.src_group == OWN_GROUP) ? 0 : 1;
        if (exp_q[NET_DEST * 2 + src].size() == 0) begin
          other_errs++;
          $display("Unexpected flit on net_out at %0t", $time);
        end else begin
          e = exp_q[NET_DEST * 2 + src].pop_front();
          check_value("net_out_dir_o", 64'(e.dir), 64'(net_out_dir_o));
          check_value("net_out_hdr_o", 64'(e.hdr), 64'(net_out_hdr_o));
          check_value("net_out_payload_o", 64'(e.payload), 64'(net_out_payload_o));
        end
      end
      if ($countones(tile_req_valid_o) > 1) begin
        other_errs++;
        $display("More than one tile valid at once at %0t", $time);
      end
      for (int k = 0; k < `NUM_TILES; k++) begin
        if (tile_req_valid_o[k]) begin
          src = (tile_req_src_group_o == OWN_GROUP) ? 0 : 1;
          if (exp_q[k * 2 + src].size() == 0) begin
            other_errs++;
            $display("Unexpected request on tile %0d at %0t", k, $time);
          end else begin
            e = exp_q[k * 2 + src].pop_front();
            check_value("tile_req_row_bank_o", 64'(e.row_bank), 64'(tile_req_row_bank_o));
            check_value("tile_req_core_id_o", 64'(e.hdr.core_id), 64'(tile_req_core_id_o));
            check_value("tile_req_src_group_o", 64'(e.hdr.src_group), 64'(tile_req_src_group_o));
            check_value("tile_req_data_o", 64'(e.payload.data), 64'(tile_req_data_o));
            check_value("tile_req_be_o", 64'(e.payload.be), 64'(tile_req_be_o));
            check_value("tile_req_wen_o", 64'(e.payload.wen), 64'(tile_req_wen_o));
          end
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, traffic did not drain", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed                = 32'hd034ca32;
    checks              = 0;
    mismatches          = 0;
    other_errs          = 0;
    local_left          = 0;
    net_left            = 0;
    net_sent            = 0;
    net_credit_pulses   = 0;
    net_in_cnt          = `FIFO_DEPTH;
    net_owed            = 0;
    hold_net            = 1'b0;
    hold_tile           = 1'b0;
    for (int k = 0; k < `NUM_TILES; k++) tile_owed[k] = 0;
    rst_n_i             = 1'b0;
    group_id_i          = OWN_GROUP;
    mst_req_valid_i     = 1'b0;
    mst_req_addr_i      = '0;
    mst_req_dst_group_i = '0;
    mst_req_core_id_i   = '0;
    mst_req_data_i      = '0;
    mst_req_be_i        = '0;
    mst_req_wen_i       = 1'b0;
    net_in_valid_i      = 1'b0;
    net_in_hdr_i        = '0;
    net_in_payload_i    = '0;
    net_out_credit_i    = 1'b0;
    tile_credit_i       = '0;
    repeat (3) @(posedge clk_i);
    #1 rst_n_i = 1'b1;

    @(negedge clk_i);
    check_value("tile_req_valid_o", 64'(0), 64'(tile_req_valid_o));
    check_value("net_out_valid_o", 64'(0), 64'(net_out_valid_o));
    check_value("net_in_credit_o", 64'(0), 64'(net_in_credit_o));
    check_value("mst_req_ready_o", 64'(1), 64'(mst_req_ready_o));

    // Mixed local and incoming traffic with live credits
    local_left = N_LOCAL;
    net_left   = N_NET;
    while (local_left > 0 || net_left > 0) @(posedge clk_i);

    // Withhold all credits until the master is stalled
    hold_net    = 1'b1;
    hold_tile   = 1'b1;
    local_left  = N_BP;
    wait_cycles = 0;
    while (mst_req_ready_o && wait_cycles < 200) begin
      @(posedge clk_i);
      #2;
      wait_cycles++;
    end
    if (mst_req_ready_o) begin
      other_errs++;
      $display("mst_req_ready_o stayed high while credits were withheld");
    end
    repeat (20) @(posedge clk_i);
    hold_net  = 1'b0;
    hold_tile = 1'b0;

    while (local_left > 0 || !queues_empty()) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    check_value("net_in_credit_o pulses", 64'(net_sent), 64'(net_credit_pulses));

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/noc_group_endpoint.sv
// Group network endpoint
// Packetizer, XY route unit and tile demux joined by credit-based flit links

`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_group_endpoint (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  noc_pkg::group_xy_t        group_id_i,
  // Local master
  input  logic                      mst_req_valid_i,
  output logic                      mst_req_ready_o,
  input  logic [`TCDM_ADDR_W-1:0]   mst_req_addr_i,
  input  noc_pkg::group_xy_t        mst_req_dst_group_i,
  input  logic [`CORE_ID_W-1:0]     mst_req_core_id_i,
  input  logic [`DATA_W-1:0]        mst_req_data_i,
  input  logic [`BE_W-1:0]          mst_req_be_i,
  input  logic                      mst_req_wen_i,
  // Network links
  input  logic                      net_in_valid_i,
  input  noc_pkg::req_hdr_t         net_in_hdr_i,
  input  noc_pkg::req_payload_t     net_in_payload_i,
  output logic                      net_in_credit_o,
  output logic                      net_out_valid_o,
  output noc_pkg::req_hdr_t         net_out_hdr_o,
  output noc_pkg::req_payload_t     net_out_payload_o,
  output noc_pkg::dir_e             net_out_dir_o,
  input  logic                      net_out_credit_i,
  // Tiles
  input  logic [`NUM_TILES-1:0]     tile_credit_i,
  output logic [`NUM_TILES-1:0]     tile_req_valid_o,
  output logic [`ROW_W+`BANK_W-1:0] tile_req_row_bank_o,
  output logic [`CORE_ID_W-1:0]     tile_req_core_id_o,
  output noc_pkg::group_xy_t        tile_req_src_group_o,
  output logic [`DATA_W-1:0]        tile_req_data_o,
  output logic [`BE_W-1:0]          tile_req_be_o,
  output logic                      tile_req_wen_o
);

  flit_link_if pkt_link ();   // Packetizer to route unit
  flit_link_if eject_link (); // Route unit to tile demux

  req_packetizer i_req_packetizer (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .group_id_i          (group_id_i),
    .mst_req_valid_i     (mst_req_valid_i),
    .mst_req_addr_i      (mst_req_addr_i),
    .mst_req_dst_group_i (mst_req_dst_group_i),
    .mst_req_core_id_i   (mst_req_core_id_i),
    .mst_req_data_i      (mst_req_data_i),
    .mst_req_be_i        (mst_req_be_i),
    .mst_req_wen_i       (mst_req_wen_i),
    .mst_req_ready_o     (mst_req_ready_o),
    .pkt_link            (pkt_link.tx)
  );

  xy_route_unit i_xy_route_unit (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .group_id_i        (group_id_i),
    .pkt_link          (pkt_link.rx),
    .net_in_valid_i    (net_in_valid_i),
    .net_in_hdr_i      (net_in_hdr_i),
    .net_in_payload_i  (net_in_payload_i),
    .net_in_credit_o   (net_in_credit_o),
    .net_out_valid_o   (net_out_valid_o),
    .net_out_hdr_o     (net_out_hdr_o),
    .net_out_payload_o (net_out_payload_o),
    .net_out_dir_o     (net_out_dir_o),
    .net_out_credit_i  (net_out_credit_i),
    .eject_link        (eject_link.tx)
  );

  tile_req_demux i_tile_req_demux (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .eject_link           (eject_link.rx),
    .tile_credit_i        (tile_credit_i),
    .tile_req_valid_o     (tile_req_valid_o),
    .tile_req_row_bank_o  (tile_req_row_bank_o),
    .tile_req_core_id_o   (tile_req_core_id_o),
    .tile_req_src_group_o (tile_req_src_group_o),
    .tile_req_data_o      (tile_req_data_o),
    .tile_req_be_o        (tile_req_be_o),
    .tile_req_wen_o       (tile_req_wen_o)
  );

endmodule

//--- logic/tile_req_demux.sv
// Tile request demux
// Picks the target tile from the low address bits and delivers with per-tile credits

`timescale 1ns/1ps
`include "noc_consts.svh"

module tile_req_demux (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  flit_link_if.rx                       eject_link,
  input  logic [`NUM_TILES-1:0]         tile_credit_i,
  output logic [`NUM_TILES-1:0]         tile_req_valid_o,
  output logic [`ROW_W+`BANK_W-1:0]     tile_req_row_bank_o,
  output logic [`CORE_ID_W-1:0]         tile_req_core_id_o,
  output noc_pkg::group_xy_t            tile_req_src_group_o,
  output logic [`DATA_W-1:0]            tile_req_data_o,
  output logic [`BE_W-1:0]              tile_req_be_o,
  output logic                          tile_req_wen_o
);

  localparam int PTR_W  = $clog2(`FIFO_DEPTH);
  localparam int CNT_W  = $clog2(`FIFO_DEPTH + 1);
  localparam int TCNT_W = $clog2(`TILE_CREDITS + 1);

  noc_pkg::req_hdr_t     hdr_mem [`FIFO_DEPTH];
  noc_pkg::req_payload_t pay_mem [`FIFO_DEPTH];
  logic [PTR_W-1:0]      wptr_q;
  logic [PTR_W-1:0]      rptr_q;
  logic [CNT_W-1:0]      cnt_q;
  logic [TCNT_W-1:0]     tile_cnt_q [`NUM_TILES];
  noc_pkg::req_hdr_t     head_hdr;
  logic [`TILE_W-1:0]    head_tile;
  logic                  pop;

  assign head_hdr  = hdr_mem[rptr_q];
  assign head_tile = head_hdr.tcdm_addr.fields.tile;
  assign pop       = (cnt_q != '0) && (tile_cnt_q[head_tile] != '0);

  always_ff @(posedge clk_i) begin
    if (eject_link.valid) begin
      hdr_mem[wptr_q] <= eject_link.hdr;
      pay_mem[wptr_q] <= eject_link.payload;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q           <= '0;
      rptr_q           <= '0;
      cnt_q            <= '0;
      tile_req_valid_o <= '0;
      eject_link.credit <= 1'b0;
      for (int k = 0; k < `NUM_TILES; k++) begin
        tile_cnt_q[k] <= TCNT_W'(`TILE_CREDITS);
      end
    end else begin
      if (eject_link.valid) begin
        wptr_q <= (wptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(eject_link.valid) - CNT_W'(pop);
      for (int k = 0; k < `NUM_TILES; k++) begin
        tile_cnt_q[k] <= tile_cnt_q[k] - TCNT_W'(pop && (int'(head_tile) == k))
                         + TCNT_W'(tile_credit_i[k]);
      end
      tile_req_valid_o <= '0;
      if (pop) begin
        tile_req_valid_o[head_tile] <= 1'b1; // One-hot on the decoded tile
      end
      eject_link.credit <= pop;
    end
  end

  // Delivered fields, tile bits dropped from the address
  always_ff @(posedge clk_i) begin
    if (pop) begin
      tile_req_row_bank_o  <= {head_hdr.tcdm_addr.fields.row, head_hdr.tcdm_addr.fields.bank};
      tile_req_core_id_o   <= head_hdr.core_id;
      tile_req_src_group_o <= head_hdr.src_group;
      tile_req_data_o      <= pay_mem[rptr_q].data;
      tile_req_be_o        <= pay_mem[rptr_q].be;
      tile_req_wen_o       <= pay_mem[rptr_q].wen;
    end
  end

endmodule

//--- logic/xy_route_unit.sv
// XY route unit
// Buffers local and network flits, picks one per cycle round-robin, routes it X then Y

`timescale 1ns/1ps
`include "noc_consts.svh"

module xy_route_unit (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  noc_pkg::group_xy_t    group_id_i,
  flit_link_if.rx               pkt_link,
  input  logic                  net_in_valid_i,
  input  noc_pkg::req_hdr_t     net_in_hdr_i,
  input  noc_pkg::req_payload_t net_in_payload_i,
  output logic                  net_in_credit_o,
  output logic                  net_out_valid_o,
  output noc_pkg::req_hdr_t     net_out_hdr_o,
  output noc_pkg::req_payload_t net_out_payload_o,
  output noc_pkg::dir_e         net_out_dir_o,
  input  logic                  net_out_credit_i,
  flit_link_if.tx               eject_link
);

  localparam int PTR_W     = $clog2(`FIFO_DEPTH);
  localparam int CNT_W     = $clog2(`FIFO_DEPTH + 1);
  localparam int NET_CNT_W = $clog2(`NET_CREDITS + 1);
  localparam int SRC_LOCAL = 0;
  localparam int SRC_NET   = 1;

  logic [1:0]            in_valid;
  noc_pkg::req_hdr_t     in_hdr [2];
  noc_pkg::req_payload_t in_payload [2];
  logic [1:0]            head_valid;
  noc_pkg::req_hdr_t     head_hdr [2];
  noc_pkg::req_payload_t head_payload [2];
  logic [1:0]            head_local;
  noc_pkg::dir_e         head_dir [2];
  logic [1:0]            eligible;
  logic [1:0]            pop;
  logic                  grant_idx;
  logic                  go;
  logic                  go_local;
  logic                  rr_q;
  logic [NET_CNT_W-1:0]  net_cnt_q;
  logic [CNT_W-1:0]      eject_cnt_q;
  noc_pkg::req_hdr_t     out_hdr_q;
  noc_pkg::req_payload_t out_payload_q;

  assign in_valid[SRC_LOCAL]   = pkt_link.valid;
  assign in_hdr[SRC_LOCAL]     = pkt_link.hdr;
  assign in_payload[SRC_LOCAL] = pkt_link.payload;
  assign in_valid[SRC_NET]     = net_in_valid_i;
  assign in_hdr[SRC_NET]       = net_in_hdr_i;
  assign in_payload[SRC_NET]   = net_in_payload_i;

  // Input FIFOs, never overrun since senders hold credits
  for (genvar g = 0; g < 2; g++) begin : gen_fifo
    noc_pkg::req_hdr_t     hdr_mem [`FIFO_DEPTH];
    noc_pkg::req_payload_t pay_mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]      wptr_q;
    logic [PTR_W-1:0]      rptr_q;
    logic [CNT_W-1:0]      cnt_q;

    always_ff @(posedge clk_i) begin
      if (in_valid[g]) begin
        hdr_mem[wptr_q] <= in_hdr[g];
        pay_mem[wptr_q] <= in_payload[g];
      end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (in_valid[g]) begin
          wptr_q <= (wptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
        end
        if (pop[g]) begin
          rptr_q <= (rptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
        end
        cnt_q <= cnt_q + CNT_W'(in_valid[g]) - CNT_W'(pop[g]);
      end
    end

    assign head_valid[g]   = (cnt_q != '0);
    assign head_hdr[g]     = hdr_mem[rptr_q];
    assign head_payload[g] = pay_mem[rptr_q];
  end

  // Dimension order: X first, then Y, else eject
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      head_local[i] = 1'b0;
      head_dir[i]   = noc_pkg::NORTH;
      if (head_hdr[i].dst_group.x != group_id_i.x) begin
        head_dir[i] = (head_hdr[i].dst_group.x > group_id_i.x) ? noc_pkg::EAST : noc_pkg::WEST;
      end else if (head_hdr[i].dst_group.y != group_id_i.y) begin
        head_dir[i] = (head_hdr[i].dst_group.y > group_id_i.y) ? noc_pkg::NORTH : noc_pkg::SOUTH;
      end else begin
        head_local[i] = 1'b1;
      end
      eligible[i] = head_valid[i] &&
                    (head_local[i] ? (eject_cnt_q != '0) : (net_cnt_q != '0));
    end
  end

  // Round-robin over heads whose destination has credit
  always_comb begin
    grant_idx      = eligible[rr_q] ? rr_q : ~rr_q;
    pop            = '0;
    pop[grant_idx] = eligible[grant_idx];
  end

  assign go       = |pop;
  assign go_local = go && head_local[grant_idx];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q             <= 1'b0;
      net_cnt_q        <= NET_CNT_W'(`NET_CREDITS);
      eject_cnt_q      <= CNT_W'(`FIFO_DEPTH);
      net_out_valid_o  <= 1'b0;
      eject_link.valid <= 1'b0;
      net_in_credit_o  <= 1'b0;
      pkt_link.credit  <= 1'b0;
    end else begin
      if (go) begin
        rr_q <= ~grant_idx; // Other source first next time
      end
      net_cnt_q <= net_cnt_q - NET_CNT_W'(go && !go_local) + NET_CNT_W'(net_out_credit_i);
      eject_cnt_q      <= eject_cnt_q - CNT_W'(go_local) + CNT_W'(eject_link.credit);
      net_out_valid_o  <= go && !go_local;
      eject_link.valid <= go_local;
      pkt_link.credit  <= pop[SRC_LOCAL]; // One credit per freed entry
      net_in_credit_o  <= pop[SRC_NET];
    end
  end

  always_ff @(posedge clk_i) begin
    if (go) begin
      out_hdr_q     <= head_hdr[grant_idx];
      out_payload_q <= head_payload[grant_idx];
      net_out_dir_o <= head_dir[grant_idx];
    end
  end

  // Same register feeds both exits, only one valid is raised
  assign net_out_hdr_o      = out_hdr_q;
  assign net_out_payload_o  = out_payload_q;
  assign eject_link.hdr     = out_hdr_q;
  assign eject_link.payload = out_payload_q;

endmodule

//--- logic/req_packetizer.sv
// Request packetizer
// Packs local master requests into flits and tracks credits toward the route unit

`timescale 1ns/1ps
`include "noc_consts.svh"

module req_packetizer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  noc_pkg::group_xy_t      group_id_i,
  input  logic                    mst_req_valid_i,
  input  logic [`TCDM_ADDR_W-1:0] mst_req_addr_i,
  input  noc_pkg::group_xy_t      mst_req_dst_group_i,
  input  logic [`CORE_ID_W-1:0]   mst_req_core_id_i,
  input  logic [`DATA_W-1:0]      mst_req_data_i,
  input  logic [`BE_W-1:0]        mst_req_be_i,
  input  logic                    mst_req_wen_i,
  output logic                    mst_req_ready_o,
  flit_link_if.tx                 pkt_link
);

  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  logic [CNT_W-1:0] credit_cnt_q;
  logic             accept;

  assign mst_req_ready_o = (credit_cnt_q != '0); // Room left in the local FIFO
  assign accept          = mst_req_valid_i && mst_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q   <= CNT_W'(`FIFO_DEPTH);
      pkt_link.valid <= 1'b0;
    end else begin
      pkt_link.valid <= accept;
      credit_cnt_q   <= credit_cnt_q - CNT_W'(accept) + CNT_W'(pkt_link.credit);
    end
  end

  // Flit fields, loaded only on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_link.hdr.src_group      <= group_id_i;
      pkt_link.hdr.dst_group      <= mst_req_dst_group_i;
      pkt_link.hdr.core_id        <= mst_req_core_id_i;
      pkt_link.hdr.tcdm_addr.flat <= mst_req_addr_i; // Tile bits still in place
      pkt_link.payload.data       <= mst_req_data_i;
      pkt_link.payload.be         <= mst_req_be_i;
      pkt_link.payload.wen        <= mst_req_wen_i;
    end
  end

endmodule

//--- logic/flit_link_if.sv
// Credit-based flit link
// One flit per valid cycle, one credit pulse per freed receiver entry

`timescale 1ns/1ps

interface flit_link_if;

  logic                  valid;
  noc_pkg::req_hdr_t     hdr;
  noc_pkg::req_payload_t payload;
  logic                  credit; // Receiver to sender

  modport tx (
    output valid,
    output hdr,
    output payload,
    input  credit
  );

  modport rx (
    input  valid,
    input  hdr,
    input  payload,
    output credit
  );

endinterface

//--- logic/noc_pkg.sv
// Endpoint types
// Group coordinates, route directions, TCDM address views and flit fields

`include "noc_consts.svh"

package noc_pkg;

  typedef struct packed {
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
  } group_xy_t;

  typedef enum logic [1:0] {
    NORTH = 2'd0,
    EAST  = 2'd1,
    SOUTH = 2'd2,
    WEST  = 2'd3
  } dir_e;

  // Tile index sits in the low bits
  typedef struct packed {
    logic [`ROW_W-1:0]  row;
    logic [`BANK_W-1:0] bank;
    logic [`TILE_W-1:0] tile;
  } tcdm_fields_t;

  typedef union packed {
    logic [`TCDM_ADDR_W-1:0] flat;   // As carried on the network
    tcdm_fields_t            fields; // As decoded in the group
  } tcdm_addr_u;

  typedef struct packed {
    group_xy_t              src_group;
    group_xy_t              dst_group;
    logic [`CORE_ID_W-1:0]  core_id;
    tcdm_addr_u             tcdm_addr;
  } req_hdr_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`BE_W-1:0]   be;
    logic               wen;
  } req_payload_t;

endpackage

//--- logic/noc_consts.svh
// Group endpoint constants
// Address split, field widths, buffer depths and link credit counts

`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// Tile and TCDM address split
`define NUM_TILES 4
`define TILE_W 2
`define BANK_W 2
`define ROW_W 6
`define TCDM_ADDR_W (`ROW_W + `BANK_W + `TILE_W)

// Mesh coordinates, per axis
`define COORD_W 2

// Request payload
`define DATA_W 32
`define BE_W 4
`define CORE_ID_W 3

// Input FIFO depth, also the credit count a sender starts with
`define FIFO_DEPTH 4

// Credits for the outgoing network link
`define NET_CREDITS 4

// Credits per tile request port
`define TILE_CREDITS 2

`endif
